//--- include/vdp_defines.svh
// NTSC frame only with 342 dots per line and 262 lines, and no vertical border handling
`ifndef VDP_DEFINES_SVH
`define VDP_DEFINES_SVH

// Dots per scan line, counted in four-clock dot phases
`define VDP_DOTS_PER_LINE 342

// Lines per frame
`define VDP_LINES_PER_FRAME 262

// VRAM byte address width for 128 KiB
`define VDP_VRAM_AW 17

// Bus address width
// Top bit picks the register bank over VRAM
`define VDP_WB_AW 18

// Text control registers behind the bus
`define VDP_NUM_REGS 8

`endif

//--- hw/vdp_pkg.sv
// Shared types only, and the dot phase encoding is fixed by the Gray order 00 01 11 10
`default_nettype none

package vdp_pkg;

    // Four dot phases of one clock each
    typedef enum logic [1:0] {
        DS_ADDR  = 2'b00,
        DS_READ  = 2'b01,
        DS_SET   = 2'b11,
        DS_SHIFT = 2'b10
    } dot_state_e;

    // Decoded screen mode
    typedef enum logic [1:0] {
        TM_OFF,
        TM_TEXT1,
        TM_TEXT2
    } text_mode_e;

    // Six fetch slots of one character group
    typedef enum logic [2:0] {
        SL_COLOR,
        SL_NAME_A,
        SL_GEN_A,
        SL_IDLE,
        SL_NAME_B,
        SL_GEN_B
    } fetch_slot_e;

endpackage

`default_nettype wire

//--- hw/vdp_text_cfg_if.sv
// Register values only, all driven by vdp_regs and held stable between bus writes
`timescale 1ns/1ps
`default_nettype none

interface vdp_text_cfg_if;
    import vdp_pkg::*;

    // Mode and blink clock source
    text_mode_e  mode;
    logic        bl_clks;
    // Colours
    logic [7:0]  frame_col;
    logic [7:0]  blink_col;
    logic [7:0]  blink_period;
    // Table bases
    logic [6:0]  name_base;
    logic [5:0]  gen_base;
    logic [10:0] col_base;

    modport ctrl (
        output mode, bl_clks, frame_col, blink_col, blink_period,
               name_base, gen_base, col_base
    );

    modport view (
        input  mode, bl_clks, frame_col, blink_col, blink_period,
               name_base, gen_base, col_base
    );

endinterface

`default_nettype wire

//--- hw/vdp_dot_timing.sv
// Free running after reset with no sync inputs, so every block derives its timing from here
`timescale 1ns/1ps
`default_nettype none
`include "vdp_defines.svh"

module vdp_dot_timing (
    input  logic                CLK21M,
    input  logic                RESET,
    output vdp_pkg::dot_state_e dot_state,
    output logic [8:0]          dot_x,
    output logic [8:0]          dot_y
);
    import vdp_pkg::*;

    always_ff @(posedge CLK21M or posedge RESET) begin
        if (RESET) begin
            dot_state <= DS_ADDR;
            dot_x     <= '0;
            dot_y     <= '0;
        end else begin
            // Phase sequencer
            case (dot_state)
                DS_ADDR: dot_state <= DS_READ;
                DS_READ: dot_state <= DS_SET;
                DS_SET:  dot_state <= DS_SHIFT;
                default: dot_state <= DS_ADDR;
            endcase

            // Counters step on the SET to SHIFT edge
            if (dot_state == DS_SET) begin
                if (dot_x == 9'(`VDP_DOTS_PER_LINE - 1)) begin
                    dot_x <= '0;
                    // End of line
                    if (dot_y == 9'(`VDP_LINES_PER_FRAME - 1)) begin
                        dot_y <= '0;
                    end else begin
                        dot_y <= dot_y + 9'd1;
                    end
                end else begin
                    dot_x <= dot_x + 9'd1;
                end
            end
        end
    end

    // Full phase cycle once entered
    ap_phase_order: assert property (@(posedge CLK21M) disable iff (RESET)
        dot_state == DS_ADDR |=> dot_state == DS_READ ##1 dot_state == DS_SET
                                 ##1 dot_state == DS_SHIFT ##1 dot_state == DS_ADDR);

endmodule

`default_nettype wire

//--- hw/vdp_regs.sv
// Wishbone classic slave with one ack per cycle, stb must stay high until ack, VRAM is write only
`timescale 1ns/1ps
`default_nettype none
`include "vdp_defines.svh"

module vdp_regs (
    input  logic                    CLK21M,
    input  logic                    RESET,
    input  logic                    wb_cyc,
    input  logic                    wb_stb,
    input  logic                    wb_we,
    input  logic [`VDP_WB_AW-1:0]   wb_adr,
    input  logic [7:0]              wb_dat_w,
    output logic [7:0]              wb_dat_r,
    output logic                    wb_ack,
    output logic                    vram_we,
    output logic [`VDP_VRAM_AW-1:0] vram_wadr,
    output logic [7:0]              vram_wdat,
    vdp_text_cfg_if.ctrl            cfg
);
    import vdp_pkg::*;

    logic [7:0] regs [0:`VDP_NUM_REGS-1];
    logic       take;
    logic       is_reg;
    logic [3:0] reg_idx;

    // ----------------------------------------
    // Bus decode
    // ----------------------------------------
    // New cycle seen, blocked while its ack is out
    assign take    = wb_cyc && wb_stb && !wb_ack;
    assign is_reg  = wb_adr[`VDP_WB_AW-1];
    assign reg_idx = wb_adr[3:0];

    always_ff @(posedge CLK21M or posedge RESET) begin
        if (RESET) begin
            wb_ack   <= 1'b0;
            wb_dat_r <= 8'h00;
            vram_we  <= 1'b0;
            for (int i = 0; i < `VDP_NUM_REGS; i++) begin
                regs[i] <= 8'h00;
            end
        end else begin
            wb_ack  <= take;
            vram_we <= take && wb_we && !is_reg;
            // Read data lines up with ack
            // VRAM range and unused registers read as zero
            if (take && !wb_we) begin
                wb_dat_r <= (is_reg && reg_idx < `VDP_NUM_REGS) ? regs[reg_idx[2:0]] : 8'h00;
            end
            // Register write lands on the ack edge
            if (take && wb_we && is_reg && reg_idx < `VDP_NUM_REGS) begin
                regs[reg_idx[2:0]] <= wb_dat_w;
            end
        end
    end

    // VRAM write payload
    always_ff @(posedge CLK21M) begin
        if (take) begin
            vram_wadr <= wb_adr[`VDP_VRAM_AW-1:0];
            vram_wdat <= wb_dat_w;
        end
    end

    // ----------------------------------------
    // Register fields
    // ----------------------------------------
    always_comb begin
        case (regs[0][3:0])
            4'd1:    cfg.mode = TM_TEXT1;
            4'd2:    cfg.mode = TM_TEXT2;
            default: cfg.mode = TM_OFF;
        endcase
    end

    assign cfg.bl_clks      = regs[0][4];
    assign cfg.name_base    = regs[1][6:0];
    assign cfg.gen_base     = regs[2][5:0];
    // Colour base high bits in register 4
    assign cfg.col_base     = {regs[4][2:0], regs[3]};
    assign cfg.frame_col    = regs[5];
    assign cfg.blink_col    = regs[6];
    assign cfg.blink_period = regs[7];

    // One clock ack
    ap_ack_single: assert property (@(posedge CLK21M) disable iff (RESET)
        wb_ack |=> !wb_ack);

endmodule

`default_nettype wire

//--- hw/vdp_vram.sv
// Contents undefined at power up, and a read of the address being written returns old data
`timescale 1ns/1ps
`default_nettype none
`include "vdp_defines.svh"

module vdp_vram (
    input  logic                    CLK21M,
    input  logic                    we,
    input  logic [`VDP_VRAM_AW-1:0] wadr,
    input  logic [7:0]              wdat,
    input  logic [`VDP_VRAM_AW-1:0] radr,
    output logic [7:0]              rdat
);

    localparam int DEPTH = 1 << `VDP_VRAM_AW;

    logic [7:0] mem [0:DEPTH-1];

    // Bus side write port
    always_ff @(posedge CLK21M) begin
        if (we) begin
            mem[wadr] <= wdat;
        end
    end

    // Render side read port
    // Data one clock after address
    always_ff @(posedge CLK21M) begin
        rdat <= mem[radr];
    end

endmodule

`default_nettype wire

//--- hw/vdp_text12.sv
// TEXT1 and TEXT2 only, rows run over the whole frame with no vertical border, VRAM latency one clock
`timescale 1ns/1ps
`default_nettype none
`include "vdp_defines.svh"

module vdp_text12 (
    input  logic                    CLK21M,
    input  logic                    RESET,
    input  vdp_pkg::dot_state_e     dot_state,
    input  logic [8:0]              dot_x,
    input  logic [8:0]              dot_y,
    vdp_text_cfg_if.view            cfg,
    output logic [`VDP_VRAM_AW-1:0] ram_adr,
    input  logic [7:0]              ram_dat,
    output logic                    disp_en,
    output logic [3:0]              color_code
);
    import vdp_pkg::*;

    // Slot 0 to 5 in the low bits
    // Group of eight TEXT2 characters above
    logic [4:0]              cnt24;
    fetch_slot_e             slot;
    logic                    pre_win;
    logic                    win_next;
    logic                    is_text1;
    logic                    is_text2;
    // Character position
    logic [6:0]              char_x;
    logic [11:0]             line_start;
    logic [11:0]             char_idx;
    logic [`VDP_VRAM_AW-1:0] adr_name;
    logic [`VDP_VRAM_AW-1:0] adr_gen;
    logic [`VDP_VRAM_AW-1:0] adr_col;
    // Fetched bytes and shifters
    logic [7:0]              pat_num;
    logic [7:0]              pre_pat;
    logic [7:0]              pre_blink;
    logic [7:0]              pattern;
    logic [7:0]              blink;
    logic [7:0]              tx_color;
    logic [3:0]              dot_color;
    // Blink phase
    logic [3:0]              blink_clk_cnt;
    logic [3:0]              blink_per_cnt;
    logic                    blink_on;
    logic [3:0]              blink_max;
    logic                    blink_sync;

    assign is_text1 = (cfg.mode == TM_TEXT1);
    assign is_text2 = (cfg.mode == TM_TEXT2);
    assign slot     = fetch_slot_e'(cnt24[2:0]);

    // ----------------------------------------
    // Table addresses
    // ----------------------------------------
    assign char_idx = line_start + {5'd0, char_x};
    // TEXT2 name table spans 4 KiB
    assign adr_name = is_text1 ? {cfg.name_base, char_idx[9:0]}
                               : {cfg.name_base[6:2], char_idx};
    assign adr_gen  = {cfg.gen_base, pat_num, dot_y[2:0]};
    // One blink byte per eight characters
    assign adr_col  = {cfg.col_base[10:3], char_idx[11:3]};

    // ----------------------------------------
    // Fetch counter and pre window
    // ----------------------------------------
    // In SHIFT dot_x already holds the next dot
    always_ff @(posedge CLK21M or posedge RESET) begin
        if (RESET) begin
            cnt24   <= '0;
            pre_win <= 1'b0;
        end else if (dot_state == DS_SHIFT) begin
            if (dot_x == 9'd12) begin
                cnt24   <= '0;
                pre_win <= (cfg.mode != TM_OFF);
            end else begin
                if (dot_x == 9'd252) begin
                    pre_win <= 1'b0;
                end
                if (cnt24[2:0] == 3'd5) begin
                    cnt24[4:3] <= cnt24[4:3] + 2'd1;
                    cnt24[2:0] <= 3'd0;
                end else begin
                    cnt24[2:0] <= cnt24[2:0] + 3'd1;
                end
            end
        end
    end

    // Address issue in SET
    always_ff @(posedge CLK21M or posedge RESET) begin
        if (RESET) begin
            ram_adr    <= '0;
            char_x     <= '0;
            line_start <= '0;
        end else begin
            case (dot_state)
                DS_SET: begin
                    if (pre_win) begin
                        case (slot)
                            SL_COLOR: begin
                                if (is_text2 && cnt24[4:3] == 2'b00) begin
                                    ram_adr <= adr_col;
                                end
                            end
                            SL_NAME_A: begin
                                ram_adr <= adr_name;
                                char_x  <= char_x + 7'd1;
                            end
                            SL_GEN_A: ram_adr <= adr_gen;
                            // Second character of a TEXT2 group
                            SL_NAME_B: begin
                                if (is_text2) begin
                                    ram_adr <= adr_name;
                                    char_x  <= char_x + 7'd1;
                                end
                            end
                            SL_GEN_B: begin
                                if (is_text2) begin
                                    ram_adr <= adr_gen;
                                end
                            end
                            default: ;
                        endcase
                    end
                end
                DS_ADDR: begin
                    if (dot_x == 9'd11) begin
                        char_x <= '0;
                        if (dot_y == 9'd0) begin
                            line_start <= '0;
                        end
                    end else if (dot_x == 9'd251 && dot_y[2:0] == 3'b111) begin
                        // Next character row
                        line_start <= char_idx;
                    end
                end
                default: ;
            endcase
        end
    end

    // Read back one slot after issue
    always_ff @(posedge CLK21M) begin
        if (dot_state == DS_READ) begin
            case (slot)
                SL_NAME_A: begin
                    if (is_text2 && cnt24[4:3] == 2'b00) begin
                        pre_blink <= ram_dat;
                    end
                end
                SL_GEN_A: pat_num <= ram_dat;
                SL_IDLE:  pre_pat <= ram_dat;
                SL_GEN_B: begin
                    if (is_text2) begin
                        pat_num <= ram_dat;
                    end
                end
                // Pattern of the B character
                SL_COLOR: begin
                    if (is_text2) begin
                        pre_pat <= ram_dat;
                    end
                end
                default: ;
            endcase
        end
    end

    // ----------------------------------------
    // Pattern shifter
    // ----------------------------------------
    always_ff @(posedge CLK21M) begin
        case (dot_state)
            DS_ADDR: begin
                if (slot == SL_NAME_B || (is_text2 && slot == SL_NAME_A)) begin
                    pattern <= pre_pat;
                    // Blink bits follow the character loads
                    blink <= (cnt24 == 5'b00100) ? pre_blink : {blink[6:0], 1'b0};
                end
            end
            DS_READ: pattern <= {pattern[6:0], 1'b0};
            DS_SHIFT: begin
                if (is_text2) begin
                    pattern <= {pattern[6:0], 1'b0};
                end
            end
            default: ;
        endcase
    end

    // ----------------------------------------
    // Colour select
    // ----------------------------------------
    assign tx_color  = (is_text2 && blink_on && blink[7]) ? cfg.blink_col : cfg.frame_col;
    assign dot_color = pattern[7] ? tx_color[7:4] : tx_color[3:0];
    // Window from dot 16 up to 256
    assign win_next  = (cfg.mode != TM_OFF) &&
                       (dot_x == 9'd16 || (disp_en && dot_x != 9'd256));

    always_ff @(posedge CLK21M or posedge RESET) begin
        if (RESET) begin
            disp_en    <= 1'b0;
            color_code <= 4'h0;
        end else if (dot_state == DS_READ) begin
            disp_en    <= win_next;
            color_code <= win_next ? dot_color : cfg.frame_col[3:0];
        end else if (dot_state == DS_SHIFT && is_text2) begin
            // Second half dot
            color_code <= disp_en ? dot_color : cfg.frame_col[3:0];
        end
    end

    // ----------------------------------------
    // Blink timing
    // ----------------------------------------
    assign blink_max  = blink_on ? cfg.blink_period[7:4] : cfg.blink_period[3:0];
    // Frame start, or every line start when bl_clks is set
    assign blink_sync = (dot_state == DS_ADDR) && (dot_x == 9'd0) &&
                        (cfg.bl_clks || dot_y == 9'd0);

    always_ff @(posedge CLK21M or posedge RESET) begin
        if (RESET) begin
            blink_clk_cnt <= '0;
            blink_per_cnt <= '0;
            blink_on      <= 1'b0;
        end else if (blink_sync) begin
            // Ten syncs per period unit
            if (blink_clk_cnt == 4'd9) begin
                blink_clk_cnt <= '0;
                blink_per_cnt <= blink_per_cnt + 4'd1;
            end else begin
                blink_clk_cnt <= blink_clk_cnt + 4'd1;
            end
            if (blink_per_cnt >= blink_max) begin
                blink_per_cnt <= '0;
                if (cfg.blink_period[7:4] == 4'd0) begin
                    blink_on <= 1'b0;
                end else if (cfg.blink_period[3:0] == 4'd0) begin
                    blink_on <= 1'b1;
                end else begin
                    blink_on <= ~blink_on;
                end
            end
        end
    end

    // VRAM address moves only out of SET
    ap_adr_in_set: assert property (@(posedge CLK21M) disable iff (RESET)
        !$stable(ram_adr) |-> $past(dot_state) == DS_SET);

    // TEXT1 keeps to the A slots
    ap_text1_a_only: assert property (@(posedge CLK21M) disable iff (RESET)
        !$stable(ram_adr) && $past(is_text1) |-> $past(slot) inside {SL_NAME_A, SL_GEN_A});

endmodule

`default_nettype wire

//--- hw/vdp_text_top.sv
// Text display core only, color_code is a palette index and needs an external palette and DAC
`timescale 1ns/1ps
`default_nettype none
`include "vdp_defines.svh"

module vdp_text_top (
    input  logic                  CLK21M,
    input  logic                  RESET,
    // Wishbone classic
    input  logic                  wb_cyc,
    input  logic                  wb_stb,
    input  logic                  wb_we,
    input  logic [`VDP_WB_AW-1:0] wb_adr,
    input  logic [7:0]            wb_dat_w,
    output logic [7:0]            wb_dat_r,
    output logic                  wb_ack,
    // Video timing and pixels
    output vdp_pkg::dot_state_e   dot_state,
    output logic [8:0]            dot_x,
    output logic [8:0]            dot_y,
    output logic                  disp_en,
    output logic [3:0]            color_code
);

    // Bus write side of VRAM
    logic                    vram_we;
    logic [`VDP_VRAM_AW-1:0] vram_wadr;
    logic [7:0]              vram_wdat;
    // Render read side
    logic [`VDP_VRAM_AW-1:0] ram_adr;
    logic [7:0]              ram_dat;

    vdp_text_cfg_if cfg_if ();

    vdp_dot_timing timing_i (
        .CLK21M    (CLK21M),
        .RESET     (RESET),
        .dot_state (dot_state),
        .dot_x     (dot_x),
        .dot_y     (dot_y)
    );

    vdp_regs regs_i (
        .CLK21M    (CLK21M),
        .RESET     (RESET),
        .wb_cyc    (wb_cyc),
        .wb_stb    (wb_stb),
        .wb_we     (wb_we),
        .wb_adr    (wb_adr),
        .wb_dat_w  (wb_dat_w),
        .wb_dat_r  (wb_dat_r),
        .wb_ack    (wb_ack),
        .vram_we   (vram_we),
        .vram_wadr (vram_wadr),
        .vram_wdat (vram_wdat),
        .cfg       (cfg_if)
    );

    vdp_vram vram_i (
        .CLK21M (CLK21M),
        .we     (vram_we),
        .wadr   (vram_wadr),
        .wdat   (vram_wdat),
        .radr   (ram_adr),
        .rdat   (ram_dat)
    );

    vdp_text12 text_i (
        .CLK21M     (CLK21M),
        .RESET      (RESET),
        .dot_state  (dot_state),
        .dot_x      (dot_x),
        .dot_y      (dot_y),
        .cfg        (cfg_if),
        .ram_adr    (ram_adr),
        .ram_dat    (ram_dat),
        .disp_en    (disp_en),
        .color_code (color_code)
    );

endmodule

`default_nettype wire

//--- verif/tb_vdp_text.sv
// Checks TEXT1 rows 0 and 1 and one TEXT2 line, relies on a fixed table layout and bl_clks line syncs
`timescale 1ns/1ps
`default_nettype none
`include "vdp_defines.svh"

module tb_vdp_text;
    import vdp_pkg::*;

    // One frame in clocks
    localparam longint FRAME_CLKS = `VDP_DOTS_PER_LINE * `VDP_LINES_PER_FRAME * 4;
    localparam logic [7:0] TEXT_COL  = 8'hf4;
    localparam logic [7:0] BLINK_COL = 8'h9a;

    logic                  CLK21M;
    logic                  RESET;
    logic                  wb_cyc;
    logic                  wb_stb;
    logic                  wb_we;
    logic [`VDP_WB_AW-1:0] wb_adr;
    logic [7:0]            wb_dat_w;
    logic [7:0]            wb_dat_r;
    logic                  wb_ack;
    dot_state_e            dot_state;
    logic [8:0]            dot_x;
    logic [8:0]            dot_y;
    logic                  disp_en;
    logic [3:0]            color_code;

    // Golden VRAM image and expected line
    logic [7:0]  img [0:(1 << `VDP_VRAM_AW) - 1];
    logic [3:0]  exp_line [0:479];
    int          exp_len;
    int          pos;
    string       test_name;
    logic        capture_on;
    logic        half_dots;
    logic        sample_now;
    logic        bg_ok;
    logic [3:0]  bg_exp;
    logic [31:0] lcg_state;
    logic [7:0]  rd;
    longint      tick;

    vdp_text_top dut_i (
        .CLK21M     (CLK21M),
        .RESET      (RESET),
        .wb_cyc     (wb_cyc),
        .wb_stb     (wb_stb),
        .wb_we      (wb_we),
        .wb_adr     (wb_adr),
        .wb_dat_w   (wb_dat_w),
        .wb_dat_r   (wb_dat_r),
        .wb_ack     (wb_ack),
        .dot_state  (dot_state),
        .dot_x      (dot_x),
        .dot_y      (dot_y),
        .disp_en    (disp_en),
        .color_code (color_code)
    );

    always #10 CLK21M = ~CLK21M;

    // Results of READ seen in SET, results of SHIFT seen in ADDR
    assign sample_now = (dot_state == DS_SET) || (half_dots && dot_state == DS_ADDR);

    always @(posedge CLK21M) begin
        if (!capture_on) begin
            pos <= 0;
        end else if (sample_now && disp_en) begin
            pos <= pos + 1;
        end
    end

    // Clocks since reset release
    always @(posedge CLK21M) begin
        if (RESET) begin
            tick <= 0;
        end else begin
            tick <= tick + 1;
        end
    end

    task automatic report_fail(input string msg);
        $display("%s", msg);
        $display("CHECKS FAILED");
        $fatal(1, "run stopped");
    endtask

    function automatic logic [7:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state[23:16];
    endfunction

    // Four clocks per dot in the order ADDR READ SET SHIFT
    function automatic dot_state_e phase_at(input longint t);
        case (t % 4)
            0:       return DS_ADDR;
            1:       return DS_READ;
            2:       return DS_SET;
            default: return DS_SHIFT;
        endcase
    endfunction

    // Counters step on the SET to SHIFT edge
    function automatic logic [8:0] x_at(input longint t);
        return 9'(((t + 1) / 4) % `VDP_DOTS_PER_LINE);
    endfunction

    function automatic logic [8:0] y_at(input longint t);
        return 9'(((t + 1) / (4 * `VDP_DOTS_PER_LINE)) % `VDP_LINES_PER_FRAME);
    endfunction

    // ----------------------------------------
    // Checkers
    // ----------------------------------------
    // Dot phase and counters against the clock count
    ap_timing: assert property (@(posedge CLK21M) disable iff (RESET)
        dot_state == phase_at(tick) && dot_x == x_at(tick) && dot_y == y_at(tick))
        else report_fail($sformatf("mismatch timing expected %0d %0d %0d actual %0d %0d %0d",
                                   phase_at($sampled(tick)), x_at($sampled(tick)),
                                   y_at($sampled(tick)), $sampled(dot_state),
                                   $sampled(dot_x), $sampled(dot_y)));

    // Border and blanking show the background nibble
    ap_border: assert property (@(posedge CLK21M) disable iff (RESET)
        (bg_ok && dot_state == DS_SET && !disp_en) |-> color_code == bg_exp)
        else report_fail($sformatf("mismatch border expected %h actual %h", bg_exp, color_code));

    // Window dots against the golden line
    ap_line: assert property (@(posedge CLK21M) disable iff (RESET)
        (capture_on && sample_now && disp_en) |-> (pos < exp_len && color_code == exp_line[pos]))
        else report_fail($sformatf("mismatch %s sample %0d expected %h actual %h",
                                   test_name, $sampled(pos), exp_line[$sampled(pos)],
                                   $sampled(color_code)));

    // ----------------------------------------
    // Bus tasks
    // ----------------------------------------
    task automatic bus_cycle(input logic we, input logic [17:0] adr, input logic [7:0] dat,
                             output logic [7:0] rdat);
        @(posedge CLK21M);
        wb_cyc   <= 1'b1;
        wb_stb   <= 1'b1;
        wb_we    <= we;
        wb_adr   <= adr;
        wb_dat_w <= dat;
        @(posedge CLK21M);
        while (!wb_ack) @(posedge CLK21M);
        rdat = wb_dat_r;
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
        wb_we  <= 1'b0;
    endtask

    task automatic write_vram(input logic [16:0] adr, input logic [7:0] dat);
        logic [7:0] unused;
        img[adr] = dat;
        bus_cycle(1'b1, {1'b0, adr}, dat, unused);
    endtask

    task automatic write_reg(input logic [3:0] idx, input logic [7:0] dat);
        logic [7:0] unused;
        bus_cycle(1'b1, {1'b1, 13'd0, idx}, dat, unused);
    endtask

    task automatic wait_dot(input int y, input int x);
        do @(posedge CLK21M);
        while (!(dot_y == 9'(y) && dot_x == 9'(x) && dot_state == DS_ADDR));
    endtask

    // ----------------------------------------
    // Golden line from the table rules
    // ----------------------------------------
    task automatic build_line(input bit text2, input int y, input bit blink_on);
        int          n;
        int          idx;
        logic [16:0] a;
        logic [7:0]  name;
        logic [7:0]  pat;
        logic [7:0]  col;
        logic [7:0]  tx;
        n = text2 ? 80 : 40;
        exp_len = n * 6;
        for (int k = 0; k < n; k++) begin
            // Row start moves by one line of characters every 8 lines
            idx  = (y / 8) * n + k;
            a    = text2 ? 17'h01000 + 17'(idx) : 17'(idx);
            name = img[a];
            pat  = img[{6'h01, name, 3'(y)}];
            col  = img[17'h00400 + 17'(idx / 8)];
            tx   = (text2 && blink_on && col[7 - (idx % 8)]) ? BLINK_COL : TEXT_COL;
            // Top six bits, MSB first
            for (int b = 0; b < 6; b++) begin
                exp_line[k * 6 + b] = pat[7 - b] ? tx[7:4] : tx[3:0];
            end
        end
    endtask

    task automatic capture_line(input string name, input bit text2, input int y,
                                input bit blink_on);
        int got;
        build_line(text2, y, blink_on);
        test_name <= name;
        half_dots <= text2;
        wait_dot(y, 2);
        capture_on <= 1'b1;
        wait_dot(y, 300);
        got = pos;
        capture_on <= 1'b0;
        assert (got == exp_len)
            else report_fail($sformatf("mismatch %s count expected %0d actual %0d",
                                       name, exp_len, got));
    endtask

    // Three frames plus setup slack
    initial begin
        repeat (3 * FRAME_CLKS + 40000) @(posedge CLK21M);
        report_fail("timeout, the test sequence did not finish in time");
    end

    // ----------------------------------------
    // Main sequence
    // ----------------------------------------
    initial begin
        logic [7:0] reg_vals [0:7];
        // Bits above the used fields are stored and read back too
        reg_vals = '{8'h10, 8'h80, 8'h01, 8'h10, 8'hf8, TEXT_COL, BLINK_COL, 8'h10};
        CLK21M     = 1'b0;
        RESET      = 1'b1;
        wb_cyc     = 1'b0;
        wb_stb     = 1'b0;
        wb_we      = 1'b0;
        wb_adr     = '0;
        wb_dat_w   = 8'h00;
        capture_on = 1'b0;
        half_dots  = 1'b0;
        bg_ok      = 1'b0;
        bg_exp     = 4'h0;
        exp_len    = 0;
        test_name  = "idle";
        lcg_state  = 32'h07c8_e1a9;
        repeat (10) @(posedge CLK21M);
        RESET <= 1'b0;
        bg_ok <= 1'b1;
        repeat (3) @(posedge CLK21M);
        assert (disp_en == 1'b0 && color_code == 4'h0)
            else report_fail($sformatf("mismatch reset expected 0 0 actual %b %h",
                                       disp_en, color_code));

        // Register readback, border is in flux meanwhile
        bg_ok <= 1'b0;
        for (int i = 0; i < 8; i++) begin
            write_reg(4'(i), reg_vals[i]);
        end
        for (int i = 0; i < 8; i++) begin
            bus_cycle(1'b0, {1'b1, 13'd0, 4'(i)}, 8'h00, rd);
            assert (rd == reg_vals[i])
                else report_fail($sformatf("mismatch reg%0d expected %h actual %h",
                                           i, reg_vals[i], rd));
        end
        repeat (8) @(posedge CLK21M);
        bg_exp <= TEXT_COL[3:0];
        bg_ok  <= 1'b1;

        // Generator, both name tables, blink table
        for (int i = 0; i < 2048; i++) begin
            write_vram(17'h00800 + 17'(i), lcg_next());
        end
        for (int i = 0; i < 80; i++) begin
            write_vram(17'(i), lcg_next());
            write_vram(17'h01000 + 17'(i), lcg_next());
        end
        for (int i = 0; i < 10; i++) begin
            write_vram(17'h00400 + 17'(i), lcg_next());
        end

        // TEXT1 from the next frame
        wait_dot(100, 0);
        write_reg(4'd0, 8'h01);
        capture_line("text1_line0", 1'b0, 0, 1'b0);
        capture_line("text1_line9", 1'b0, 9, 1'b0);

        // TEXT2 with line sync blink, on time only
        write_reg(4'd1, 8'h04);
        write_reg(4'd0, 8'h12);
        capture_line("text2_blink", 1'b1, 0, 1'b1);
        write_reg(4'd7, 8'h00);
        capture_line("text2_noblink", 1'b1, 0, 1'b0);

        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

//--- filelist.f
+incdir+include
hw/vdp_pkg.sv
hw/vdp_text_cfg_if.sv
hw/vdp_dot_timing.sv
hw/vdp_regs.sv
hw/vdp_vram.sv
hw/vdp_text12.sv
hw/vdp_text_top.sv
verif/tb_vdp_text.sv

//--- run_sim.sh
#!/bin/sh
# Build with Verilator and run, pass only when the pass line is printed
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal -f filelist.f \
    --top-module tb_vdp_text -o sim_tb &&
./obj_dir/sim_tb | tee /dev/stderr | grep -q "ALL CHECKS PASSED" &&
echo "simulation passed" && exit 0 ||
{ echo "simulation failed"; exit 1; }
